// ==== build.f ====
design/host_cmd_pkg.sv
design/video_pkg.sv
design/host_cmd_decoder.sv
design/sync_polarity.sv
design/umuldiv.sv
design/aspect_window.sv
design/video_cfg_top.sv
tests/tb_clock.sv
tests/tb_video_cfg.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run tb_video_cfg with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_video_cfg -o tb_video_cfg_sim
./obj_dir/tb_video_cfg_sim | tee sim.log
if grep -q "Test FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "Test OK" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

// ==== tests/tb_video_cfg.sv ====
`timescale 1ns/1ps
`default_nettype none
/*
 Directed tests for video_cfg_top. Inputs change on rising edges, outputs are
 sampled on falling edges. Raw vsync is active low with a long high phase.
 Expected windows come from a behavioral model of the window rule.
*/
module tb_video_cfg;
	import host_cmd_pkg::*;
	import video_pkg::*;

	localparam int          WINDOW_WAIT  = 120;
	localparam int          VS_HIGH      = 40;
	localparam int          VS_LOW       = 4;
	localparam logic [31:0] LFSR_SEED    = 32'h4aa3_61f5;
	localparam int          BUDGET_RESET = 200;
	localparam int          BUDGET_TIMING = 150;
	localparam int          BUDGET_RATIO = 1500;
	localparam int          BUDGET_LIMIT = 1200;
	localparam int          BUDGET_VSYNC = 500;
	localparam int          TIMEOUT_CYCLES = BUDGET_RESET + BUDGET_TIMING + BUDGET_RATIO +
		BUDGET_LIMIT + BUDGET_VSYNC;

	// 1920x1080 CEA timing
	localparam video_timing_t CEA_1080P = '{
		width: 12'd1920, hfp: 12'd88, hs: 12'd44, hbp: 12'd148,
		height: 12'd1080, vfp: 12'd4, vs: 12'd5, vbp: 12'd36
	};

	logic          clk_sys;
	logic          resetd;
	logic          i_host_valid;
	host_word_t    i_host;
	logic          i_vsync;
	aspect_t       i_core_aspect;
	logic          o_host_ready;
	video_timing_t o_timing;
	video_window_t o_window;

	// Expected configuration tracked from the frames sent
	video_timing_t exp_timing;
	size_limit_t   exp_limit;
	aspect_cfg_t   exp_cfg;
	aspect_t       core;
	logic [15:0]   frame_buf [16];
	logic [31:0]   lfsr_state;
	int            checks = 0;
	int            errors = 0;
	int            cycle_cnt = 0;

	tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(2)) u_clock (
		.clk_sys (clk_sys),
		.resetd  (resetd)
	);

	video_cfg_top #(.SYNC_CNT_W(16)) i_video_cfg_top (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_host_valid  (i_host_valid),
		.i_host        (i_host),
		.i_vsync       (i_vsync),
		.i_core_aspect (i_core_aspect),
		.o_host_ready  (o_host_ready),
		.o_timing      (o_timing),
		.o_window      (o_window)
	);

	// Free-running active-low vsync
	initial begin
		i_vsync <= 1'b1;
		forever begin
			repeat (VS_HIGH) @(posedge clk_sys);
			i_vsync <= 1'b0;
			repeat (VS_LOW) @(posedge clk_sys);
			i_vsync <= 1'b1;
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Test FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Checking and reference model
	//////////////////////////////////////////////////
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("At %0t: %s", $time, msg);
	endtask

	function automatic video_window_t window_model(input video_timing_t t,
		input size_limit_t lim, input aspect_cfg_t cfg, input aspect_t core_ar);
		aspect_t       pair;
		int            width;
		int            height;
		int            eff_w;
		int            eff_h;
		int            rx;
		int            ry;
		int            pw;
		int            ph;
		int            hmin;
		int            vmin;
		video_window_t win;
		width  = int'(t.width);
		height = int'(t.height);
		eff_w  = width;
		eff_h  = height;
		if (lim.hset != '0 && int'(lim.hset) < width)
			eff_w = int'(lim.hset);
		if (lim.vset != '0 && int'(lim.vset) < height)
			eff_h = int'(lim.vset);
		// Zero y means x picks a custom ratio
		if (core_ar.y != '0)
			pair = core_ar;
		else if (core_ar.x == 13'd1)
			pair = cfg.custom1;
		else if (core_ar.x == 13'd2)
			pair = cfg.custom2;
		else
			pair = '0;
		rx = int'(pair.x[11:0]);
		ry = int'(pair.y[11:0]);
		if (lim.freescale || rx == 0 || ry == 0) begin
			pw = eff_w;
			ph = eff_h;
		end else if (pair.x[12] || pair.y[12]) begin
			pw = rx;
			ph = ry;
		end else begin
			// Only the low 12 bits of the quotient survive
			pw = (eff_h * rx / ry) % 4096;
			ph = (eff_w * ry / rx) % 4096;
		end
		if (pw > eff_w)
			pw = eff_w;
		if (ph > eff_h)
			ph = eff_h;
		hmin = (width - pw) / 2;
		vmin = (height - ph) / 2;
		win.hmin = COORD_W'(hmin);
		win.hmax = COORD_W'(hmin + pw - 1);
		win.vmin = COORD_W'(vmin);
		win.vmax = COORD_W'(vmin + ph - 1);
		return win;
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	//////////////////////////////////////////////////
	// Host port and window helpers
	//////////////////////////////////////////////////
	// Word is taken on the rising edge where the task returns
	task automatic send_word(input logic is_frame, input logic [15:0] word);
		logic rdy;
		i_host_valid <= 1'b1;
		i_host       <= '{frame: is_frame, data: word};
		do begin
			@(negedge clk_sys);
			rdy = o_host_ready;
			@(posedge clk_sys);
		end while (!rdy);
	endtask

	task automatic send_frame(input host_opcode_e opc, input int n);
		send_word(1'b1, {8'h00, 8'(opc)});
		for (int i = 0; i < n; i++)
			send_word(1'b1, frame_buf[i]);
		send_word(1'b0, 16'h0000);
		i_host_valid <= 1'b0;
	endtask

	task automatic check_timing(input video_timing_t exp);
		@(negedge clk_sys);
		check("o_timing.width", 32'(o_timing.width), 32'(exp.width));
		check("o_timing.hfp", 32'(o_timing.hfp), 32'(exp.hfp));
		check("o_timing.hs", 32'(o_timing.hs), 32'(exp.hs));
		check("o_timing.hbp", 32'(o_timing.hbp), 32'(exp.hbp));
		check("o_timing.height", 32'(o_timing.height), 32'(exp.height));
		check("o_timing.vfp", 32'(o_timing.vfp), 32'(exp.vfp));
		check("o_timing.vs", 32'(o_timing.vs), 32'(exp.vs));
		check("o_timing.vbp", 32'(o_timing.vbp), 32'(exp.vbp));
		@(posedge clk_sys);
	endtask

	// Window must settle within WINDOW_WAIT cycles
	task automatic check_window(input video_window_t exp);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (o_window !== exp && n < WINDOW_WAIT) begin
			@(negedge clk_sys);
			n++;
		end
		check("o_window.hmin", 32'(o_window.hmin), 32'(exp.hmin));
		check("o_window.hmax", 32'(o_window.hmax), 32'(exp.hmax));
		check("o_window.vmin", 32'(o_window.vmin), 32'(exp.vmin));
		check("o_window.vmax", 32'(o_window.vmax), 32'(exp.vmax));
		@(posedge clk_sys);
	endtask

	task automatic apply_core_aspect(input aspect_t a);
		core = a;
		i_core_aspect <= a;
		check_window(window_model(exp_timing, exp_limit, exp_cfg, core));
	endtask

	task automatic wait_vsync_level(input logic level);
		do @(negedge clk_sys);
		while (i_vsync != level);
	endtask

	task automatic load_timing(input video_timing_t t);
		frame_buf[0] = 16'(t.width);
		frame_buf[1] = 16'(t.hfp);
		frame_buf[2] = 16'(t.hs);
		frame_buf[3] = 16'(t.hbp);
		frame_buf[4] = 16'(t.height);
		frame_buf[5] = 16'(t.vfp);
		frame_buf[6] = 16'(t.vs);
		frame_buf[7] = 16'(t.vbp);
		send_frame(CMD_VIDEO_TIMING, 8);
		exp_timing = t;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic after_reset();
		check_timing(CEA_1080P);
		@(negedge clk_sys);
		check("o_host_ready", 32'(o_host_ready), 32'd1);
		@(posedge clk_sys);
		check_window('{hmin: 12'd0, hmax: 12'd1919, vmin: 12'd0, vmax: 12'd1079});
	endtask

	task automatic timing_frame();
		// Junk in the top nibbles and two words past the end
		frame_buf[0] = 16'hF500;
		frame_buf[1] = 16'd110;
		frame_buf[2] = 16'd40;
		frame_buf[3] = 16'd220;
		frame_buf[4] = 16'h32D0;
		frame_buf[5] = 16'd5;
		frame_buf[6] = 16'd5;
		frame_buf[7] = 16'd20;
		frame_buf[8] = 16'h0ABC;
		frame_buf[9] = 16'h0123;
		send_frame(CMD_VIDEO_TIMING, 10);
		exp_timing = '{width: 12'd1280, hfp: 12'd110, hs: 12'd40, hbp: 12'd220,
			height: 12'd720, vfp: 12'd5, vs: 12'd5, vbp: 12'd20};
		check_timing(exp_timing);
		load_timing(CEA_1080P);
		check_timing(exp_timing);
	endtask

	task automatic core_ratios();
		logic [31:0] r;
		apply_core_aspect('{x: 13'd4, y: 13'd3});
		@(negedge clk_sys);
		check("o_window width", 32'(o_window.hmax - o_window.hmin + 12'd1), 32'd1440);
		check("o_window.hmin", 32'(o_window.hmin), 32'd240);
		@(posedge clk_sys);
		repeat (8) begin
			random_bits(5, r);
			core.x = 13'(r[4:0]) + 13'd1;
			random_bits(5, r);
			core.y = 13'(r[4:0]) + 13'd1;
			apply_core_aspect(core);
		end
		apply_core_aspect('{x: 13'd4, y: 13'd3});
	endtask

	task automatic limits_and_custom();
		frame_buf[0] = 16'd1280;
		send_frame(CMD_HSET, 1);
		exp_limit.hset      = 12'd1280;
		exp_limit.freescale = 1'b0;
		apply_core_aspect(core);
		// Free scale keeps the full limited area
		frame_buf[0] = 16'h8000 | 16'd1280;
		send_frame(CMD_HSET, 1);
		exp_limit.freescale = 1'b1;
		apply_core_aspect(core);
		frame_buf[0] = 16'd0;
		send_frame(CMD_HSET, 1);
		frame_buf[0] = 16'd720;
		send_frame(CMD_VSET, 1);
		exp_limit = '{vset: 12'd720, hset: 12'd0, freescale: 1'b0};
		apply_core_aspect(core);
		// 16:9 ratio and an explicit 800x600 picture
		frame_buf[0] = 16'hE010;
		frame_buf[1] = 16'd9;
		frame_buf[2] = 16'h1320;
		frame_buf[3] = 16'd600;
		send_frame(CMD_ASPECT, 4);
		exp_cfg.custom1 = '{x: 13'd16, y: 13'd9};
		exp_cfg.custom2 = '{x: 13'h1320, y: 13'd600};
		apply_core_aspect('{x: 13'd1, y: 13'd0});
		apply_core_aspect('{x: 13'd2, y: 13'd0});
		apply_core_aspect('{x: 13'd3, y: 13'd0});
		frame_buf[0] = 16'd0;
		send_frame(CMD_VSET, 1);
		exp_limit = '0;
		apply_core_aspect('{x: 13'd4, y: 13'd3});
	endtask

	task automatic vsync_stall();
		int   k;
		int   fall_at;
		logic prev_vs;
		logic vs;
		logic rdy;
		// Let the normalizer see full periods first
		repeat (2) begin
			wait_vsync_level(1'b1);
			wait_vsync_level(1'b0);
		end
		wait_vsync_level(1'b1);
		@(posedge clk_sys);
		send_word(1'b1, {8'h00, 8'(CMD_VSYNC_WAIT)});
		i_host  <= '{frame: 1'b0, data: 16'h0000};
		k       = 0;
		fall_at = -1;
		@(negedge clk_sys);
		check("o_host_ready", 32'(o_host_ready), 32'd0);
		prev_vs = i_vsync;
		rdy     = o_host_ready;
		while (!rdy) begin
			@(posedge clk_sys);
			@(negedge clk_sys);
			k++;
			vs  = i_vsync;
			rdy = o_host_ready;
			if (prev_vs && !vs && fall_at < 0)
				fall_at = k;
			prev_vs = vs;
		end
		if (fall_at < 0)
			report_failure("Host ready came back before the raw vsync fell");
		else
			check("o_host_ready delay after vsync fall", 32'(k - fall_at), 32'd1);
		@(posedge clk_sys);
		i_host_valid <= 1'b0;
		// Parsing the next frame shows the held word was taken
		frame_buf[0] = 16'd900;
		send_frame(CMD_VSET, 1);
		exp_limit.vset = 12'd900;
		apply_core_aspect(core);
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		i_host_valid  <= 1'b0;
		i_host        <= '0;
		i_core_aspect <= '0;
		lfsr_state = LFSR_SEED;
		exp_timing = CEA_1080P;
		exp_limit  = '0;
		exp_cfg    = '0;
		core       = '0;
		@(negedge resetd);
		@(posedge clk_sys);
		after_reset();
		timing_frame();
		core_ratios();
		limits_and_custom();
		vsync_stall();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none
/*
 Clock and reset source for the testbench. Reset is synchronous, active high,
 and released on a rising clock edge after RESET_CYCLES edges.
*/
module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic resetd
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		resetd <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		resetd <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== design/video_cfg_top.sv ====
`timescale 1ns/1ps
`default_nettype none
/*
 Host configuration port with the display window calculator.
 i_vsync is the raw core vsync of either polarity, all in clk_sys.
*/
module video_cfg_top #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic                     clk_sys,
	input  logic                     resetd,
	input  logic                     i_host_valid,
	input  host_cmd_pkg::host_word_t i_host,
	input  logic                     i_vsync,
	input  video_pkg::aspect_t       i_core_aspect,
	output logic                     o_host_ready,
	output video_pkg::video_timing_t o_timing,
	output video_pkg::video_window_t o_window
);
	import video_pkg::*;

	logic        vsync_norm;
	size_limit_t limit;
	aspect_cfg_t aspect_cfg;
	logic        md_start;
	logic        md_busy;
	coord_t      md_mul1, md_mul2, md_div, md_result;

	host_cmd_decoder u_decoder (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_valid      (i_host_valid),
		.i_host       (i_host),
		.i_vsync      (vsync_norm),
		.o_ready      (o_host_ready),
		.o_timing     (o_timing),
		.o_limit      (limit),
		.o_aspect_cfg (aspect_cfg)
	);

	sync_polarity #(.SYNC_CNT_W(SYNC_CNT_W)) u_vsync_pol (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vsync),
		.o_sync  (vsync_norm)
	);

	aspect_window u_window (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_timing      (o_timing),
		.i_limit       (limit),
		.i_aspect_cfg  (aspect_cfg),
		.i_core_aspect (i_core_aspect),
		.o_md_start    (md_start),
		.o_md_mul1     (md_mul1),
		.o_md_mul2     (md_mul2),
		.o_md_div      (md_div),
		.i_md_busy     (md_busy),
		.i_md_result   (md_result),
		.o_window      (o_window)
	);

	umuldiv u_muldiv (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_result)
	);

endmodule

`default_nettype wire

// ==== design/aspect_window.sv ====
`timescale 1ns/1ps
`default_nettype none
/*
 Display window calculator. Runs passes back to back, at most 60 cycles each.
 Needs an exclusive umuldiv. The window is centred on the full active area.
*/
module aspect_window (
	input  logic                          clk_sys,
	input  logic                          resetd,
	input  video_pkg::video_timing_t      i_timing,
	input  video_pkg::size_limit_t        i_limit,
	input  video_pkg::aspect_cfg_t        i_aspect_cfg,
	input  video_pkg::aspect_t            i_core_aspect,
	output logic                          o_md_start,
	output logic [video_pkg::COORD_W-1:0] o_md_mul1,
	output logic [video_pkg::COORD_W-1:0] o_md_mul2,
	output logic [video_pkg::COORD_W-1:0] o_md_div,
	input  logic                          i_md_busy,
	input  logic [video_pkg::COORD_W-1:0] i_md_result,
	output video_pkg::video_window_t      o_window
);
	import video_pkg::*;

	typedef enum logic [2:0] {IDLE, MUL_W, WAIT_W, MUL_H, WAIT_H, CLIP, PLACE} state_e;

	state_e  state;
	aspect_t sel;
	coord_t  eff_w, eff_h, arx, ary;
	coord_t  wcalc, hcalc, videow, videoh, hoff, voff;
	logic    xy, use_eff, md_done;

	assign eff_w = (i_limit.hset != '0 && i_limit.hset < i_timing.width) ?
		i_limit.hset : i_timing.width;
	assign eff_h = (i_limit.vset != '0 && i_limit.vset < i_timing.height) ?
		i_limit.vset : i_timing.height;

	// Core y of zero selects a custom pair by x
	always_comb begin
		if (i_core_aspect.y != '0)
			sel = i_core_aspect;
		else if (i_core_aspect.x == ASPECT_W'(1))
			sel = i_aspect_cfg.custom1;
		else if (i_core_aspect.x == ASPECT_W'(2))
			sel = i_aspect_cfg.custom2;
		else
			sel = '0;
	end

	assign arx     = sel.x[COORD_W-1:0];
	assign ary     = sel.y[COORD_W-1:0];
	assign xy      = sel.x[ASPECT_W-1] | sel.y[ASPECT_W-1];
	assign use_eff = i_limit.freescale | (arx == '0) | (ary == '0);
	assign md_done = ~o_md_start & ~i_md_busy;
	assign hoff    = (i_timing.width - videow) >> 1;
	assign voff    = (i_timing.height - videoh) >> 1;

	//////////////////////////////////////////////////
	// FSM and window output
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state      <= IDLE;
			o_md_start <= 1'b0;
			o_window   <= '0;
		end else begin
			o_md_start <= 1'b0;
			case (state)
				IDLE:   state <= (use_eff | xy) ? CLIP : MUL_W;
				MUL_W: begin
					o_md_start <= 1'b1;
					state      <= WAIT_W;
				end
				WAIT_W: if (md_done) state <= MUL_H;
				MUL_H: begin
					o_md_start <= 1'b1;
					state      <= WAIT_H;
				end
				WAIT_H: if (md_done) state <= CLIP;
				CLIP:   state <= PLACE;
				PLACE: begin
					o_window.hmin <= hoff;
					o_window.hmax <= hoff + videow - 1'b1;
					o_window.vmin <= voff;
					o_window.vmax <= voff + videoh - 1'b1;
					state         <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Picture size datapath
	always_ff @(posedge clk_sys) begin
		case (state)
			IDLE: begin
				if (use_eff) begin
					wcalc <= eff_w;
					hcalc <= eff_h;
				end else if (xy) begin
					wcalc <= arx;
					hcalc <= ary;
				end
			end
			MUL_W: begin
				o_md_mul1 <= eff_h;
				o_md_mul2 <= arx;
				o_md_div  <= ary;
			end
			WAIT_W: if (md_done) wcalc <= i_md_result;
			MUL_H: begin
				o_md_mul1 <= eff_w;
				o_md_mul2 <= ary;
				o_md_div  <= arx;
			end
			WAIT_H: if (md_done) hcalc <= i_md_result;
			CLIP: begin
				videow <= (wcalc > eff_w) ? eff_w : wcalc;
				videoh <= (hcalc > eff_h) ? eff_h : hcalc;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/umuldiv.sv ====
`timescale 1ns/1ps
`default_nettype none
/*
 Sequential (a*b)/c, unsigned. Busy for 24 cycles after start.
 The quotient is truncated to 12 bits. Divide by zero returns all ones.
*/
module umuldiv (
	input  logic                          clk_sys,
	input  logic                          resetd,
	input  logic                          i_start,
	input  logic [video_pkg::COORD_W-1:0] i_mul1,
	input  logic [video_pkg::COORD_W-1:0] i_mul2,
	input  logic [video_pkg::COORD_W-1:0] i_div,
	output logic                          o_busy,
	output logic [video_pkg::COORD_W-1:0] o_result
);
	import video_pkg::*;

	localparam int PROD_W = 2 * COORD_W;
	localparam int STEP_W = $clog2(PROD_W);

	logic [PROD_W-1:0]  dq;
	logic [COORD_W-1:0] rem;
	logic [COORD_W-1:0] divisor;
	logic [STEP_W-1:0]  step;
	logic [COORD_W:0]   rem_sh;
	logic [COORD_W:0]   rem_sub;
	logic               fits;

	// Restoring step, quotient bits shift in behind the dividend
	assign rem_sh   = {rem, dq[PROD_W-1]};
	assign rem_sub  = rem_sh - {1'b0, divisor};
	assign fits     = rem_sh >= {1'b0, divisor};
	assign o_result = dq[COORD_W-1:0];

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_busy <= 1'b0;
			step   <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			step   <= STEP_W'(PROD_W - 1);
		end else if (o_busy) begin
			if (step == '0)
				o_busy <= 1'b0;
			else
				step <= step - 1'b1;
		end
	end

	// Zero divisor always fits, which gives the all-ones quotient
	always_ff @(posedge clk_sys) begin
		if (i_start) begin
			dq      <= i_mul1 * i_mul2;
			rem     <= '0;
			divisor <= i_div;
		end else if (o_busy) begin
			dq  <= {dq[PROD_W-2:0], fits};
			rem <= fits ? rem_sub[COORD_W-1:0] : rem_sh[COORD_W-1:0];
		end
	end

	// Single user must wait for the previous result
	a_no_start_busy: assert property (@(posedge clk_sys) disable iff (resetd)
		i_start |-> !o_busy);

endmodule

`default_nettype wire

// ==== design/sync_polarity.sv ====
`timescale 1ns/1ps
`default_nettype none
/*
 Sync polarity normalizer. The output is active high once one full high and
 one full low period have been seen. Phase lengths saturate at the counter width.
*/
module sync_polarity #(
	parameter int SYNC_CNT_W = 16
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);
	import video_pkg::*;

	logic                  sync_d;
	logic                  pol;
	logic [SYNC_CNT_W-1:0] run_cnt;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_d   <= 1'b0;
			pol      <= 1'b0;
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else begin
			sync_d <= i_sync;
			if (i_sync != sync_d) begin
				// Phase just ended, keep its length
				run_cnt <= '0;
				if (sync_d)
					high_len <= run_cnt;
				else
					low_len <= run_cnt;
			end else if (~&run_cnt) begin
				run_cnt <= run_cnt + 1'b1;
			end
			// Longer phase is the inactive one
			pol <= high_len > low_len;
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

`default_nettype wire

// ==== design/host_cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
/*
 Host frame parser. A word is taken when i_valid and o_ready are both high.
 After CMD_VSYNC_WAIT the port stalls until i_vsync rises (active high).
 Parameter words past the end of a command are ignored.
*/
module host_cmd_decoder (
	input  logic                     clk_sys,
	input  logic                     resetd,
	input  logic                     i_valid,
	input  host_cmd_pkg::host_word_t i_host,
	input  logic                     i_vsync,
	output logic                     o_ready,
	output video_pkg::video_timing_t o_timing,
	output video_pkg::size_limit_t   o_limit,
	output video_pkg::aspect_cfg_t   o_aspect_cfg
);
	import host_cmd_pkg::*;
	import video_pkg::*;

	localparam int CNT_W = 4;

	host_opcode_e     opcode;
	logic             in_frame;
	logic [CNT_W-1:0] word_cnt;
	logic             vs_wait;
	logic             vsync_d;
	logic             take;
	logic             param_we;

	assign o_ready  = ~vs_wait;
	assign take     = i_valid & o_ready;
	assign param_we = take & i_host.frame & in_frame;

	//////////////////////////////////////////////////
	// Frame tracking and vsync stall
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			opcode   <= CMD_VIDEO_TIMING;
			in_frame <= 1'b0;
			word_cnt <= '0;
			vs_wait  <= 1'b0;
			vsync_d  <= 1'b0;
		end else begin
			vsync_d <= i_vsync;
			if (i_vsync & ~vsync_d)
				vs_wait <= 1'b0;
			if (take) begin
				if (!i_host.frame) begin
					in_frame <= 1'b0;
				end else if (!in_frame) begin
					in_frame <= 1'b1;
					opcode   <= host_opcode_e'(i_host.data[OPC_W-1:0]);
					word_cnt <= '0;
					// Wait opcode taken in the vsync cycle waits for the next one
					if (i_host.data[OPC_W-1:0] == CMD_VSYNC_WAIT)
						vs_wait <= 1'b1;
				end else if (~&word_cnt) begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Configuration registers
	//////////////////////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_timing     <= TIMING_DEFAULT;
			o_limit      <= '0;
			o_aspect_cfg <= '0;
		end else if (param_we) begin
			case (opcode)
				CMD_VIDEO_TIMING: begin
					case (word_cnt)
						4'd0: o_timing.width  <= i_host.data[COORD_W-1:0];
						4'd1: o_timing.hfp    <= i_host.data[COORD_W-1:0];
						4'd2: o_timing.hs     <= i_host.data[COORD_W-1:0];
						4'd3: o_timing.hbp    <= i_host.data[COORD_W-1:0];
						4'd4: o_timing.height <= i_host.data[COORD_W-1:0];
						4'd5: o_timing.vfp    <= i_host.data[COORD_W-1:0];
						4'd6: o_timing.vs     <= i_host.data[COORD_W-1:0];
						4'd7: o_timing.vbp    <= i_host.data[COORD_W-1:0];
						default: ;
					endcase
				end
				CMD_VSET: begin
					if (word_cnt == '0)
						o_limit.vset <= i_host.data[COORD_W-1:0];
				end
				CMD_HSET: begin
					if (word_cnt == '0) begin
						o_limit.hset      <= i_host.data[COORD_W-1:0];
						o_limit.freescale <= i_host.data[HOST_DW-1];
					end
				end
				CMD_ASPECT: begin
					case (word_cnt)
						4'd0: o_aspect_cfg.custom1.x <= i_host.data[ASPECT_W-1:0];
						4'd1: o_aspect_cfg.custom1.y <= i_host.data[ASPECT_W-1:0];
						4'd2: o_aspect_cfg.custom2.x <= i_host.data[ASPECT_W-1:0];
						4'd3: o_aspect_cfg.custom2.y <= i_host.data[ASPECT_W-1:0];
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// Host keeps a stalled word on the port, also across a vsync wait
	a_host_hold: assert property (@(posedge clk_sys) disable iff (resetd)
		i_valid && !o_ready |=> i_valid && $stable(i_host));

endmodule

`default_nettype wire

// ==== design/video_pkg.sv ====
/*
 Video side types. Coordinates are 12 bits, so sizes above 4095 are not
 representable. Aspect fields are 13 bits with bit 12 as the explicit-size flag.
*/
`default_nettype none

package video_pkg;

	localparam int COORD_W  = 12;
	localparam int ASPECT_W = COORD_W + 1;

	typedef logic [COORD_W-1:0] coord_t;

	typedef struct packed {
		coord_t width;
		coord_t hfp;
		coord_t hs;
		coord_t hbp;
		coord_t height;
		coord_t vfp;
		coord_t vs;
		coord_t vbp;
	} video_timing_t;

	// Ratio, or pixel size when the top bit of either field is set
	typedef struct packed {
		logic [ASPECT_W-1:0] x;
		logic [ASPECT_W-1:0] y;
	} aspect_t;

	typedef struct packed {
		coord_t vset;
		coord_t hset;
		logic   freescale;
	} size_limit_t;

	typedef struct packed {
		aspect_t custom1;
		aspect_t custom2;
	} aspect_cfg_t;

	typedef struct packed {
		coord_t hmin;
		coord_t hmax;
		coord_t vmin;
		coord_t vmax;
	} video_window_t;

	// 1920x1080 CEA
	localparam video_timing_t TIMING_DEFAULT = '{
		width: 12'd1920, hfp: 12'd88, hs: 12'd44, hbp: 12'd148,
		height: 12'd1080, vfp: 12'd4, vs: 12'd5, vbp: 12'd36
	};

endpackage

`default_nettype wire

// ==== design/host_cmd_pkg.sv ====
/*
 Host port definitions. Opcodes sit in the low byte of the first frame word.
 Opcodes outside the list are carried through and ignored by the decoder.
*/
`default_nettype none

package host_cmd_pkg;

	localparam int HOST_DW = 16;
	localparam int OPC_W   = 8;

	// Kept command set
	typedef enum logic [OPC_W-1:0] {
		CMD_VIDEO_TIMING = 8'h20,
		CMD_VSET         = 8'h27,
		CMD_VSYNC_WAIT   = 8'h30,
		CMD_HSET         = 8'h37,
		CMD_ASPECT       = 8'h3A
	} host_opcode_e;

	// One word on the host port
	// Frame flag low ends the frame and the data is dropped
	typedef struct packed {
		logic               frame;
		logic [HOST_DW-1:0] data;
	} host_word_t;

endpackage

`default_nettype wire
